/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = pkt_fifo_tb
FILE_LIST = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the regression"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* pkt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo
   import pkt_fifo_pkg::*;
(
   input  logic            axi4s_out,
   input  logic            arst_n,
   input  logic            in_valid,
   input  pkt_beat_t       in_beat,
   output logic            out_valid,
   input  logic            out_ready,
   output pkt_beat_t       out_beat,
   output pkt_fifo_stats_t stats,
   output logic            oflow
);

   logic    over_len;
   mem_op_t op;
   cnt_t    free;
   cnt_t    pkts_ready;
   logic    commit_pulse;
   logic    drop_pulse;

   // --------------------
   // ingress side
   // --------------------
   pkt_len_check u_len_check (
      .axi4s_out (axi4s_out),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_last   (in_beat.last),
      .sop       (),  // control needs only last
      .over_len  (over_len)
   );

   pkt_fifo_ctrl u_ctrl (
      .axi4s_out    (axi4s_out),
      .arst_n       (arst_n),
      .in_valid     (in_valid),
      .in_last      (in_beat.last),
      .over_len     (over_len),
      .free         (free),
      .pkts_ready   (pkts_ready),
      .out_ready    (out_ready),
      .op           (op),
      .out_valid    (out_valid),
      .commit_pulse (commit_pulse),
      .drop_pulse   (drop_pulse)
   );

   // --------------------
   // storage and stats
   // --------------------
   pkt_fifo_mem u_mem (
      .axi4s_out  (axi4s_out),
      .arst_n     (arst_n),
      .op         (op),
      .wr_beat    (in_beat),
      .rd_beat    (out_beat),  // fwft head
      .free       (free),
      .pkts_ready (pkts_ready)
   );

   pkt_fifo_stats u_stats (
      .axi4s_out    (axi4s_out),
      .arst_n       (arst_n),
      .commit_pulse (commit_pulse),
      .drop_pulse   (drop_pulse),
      .stats        (stats),
      .oflow        (oflow)
   );

endmodule

`default_nettype wire

/* pkt_fifo_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo_asserts
   import pkt_fifo_pkg::*;
(
   input logic      axi4s_out,
   input logic      arst_n,
   input pkt_beat_t in_beat,
   input logic      out_valid,
   input logic      out_ready,
   input pkt_beat_t out_beat,
   input logic      oflow
);

   // --------------------
   // egress handshake
   // --------------------
   // a stalled beat stays offered
   valid_held: assert property (@(posedge axi4s_out) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid)
      else $error("out_valid fell while the egress beat was stalled");

   beat_held: assert property (@(posedge axi4s_out) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_beat))
      else $error("out_beat changed while the egress beat was stalled");

   // --------------------
   // overflow pulse
   // --------------------
   // back to back pulses only across a packet boundary
   oflow_single: assert property (@(posedge axi4s_out) disable iff (!arst_n)
      oflow |=> !oflow || $past(in_beat.last, 2))
      else $error("oflow stayed high for two cycles within one packet");

endmodule

`default_nettype wire

/* pkt_fifo_cfg.svh */
`ifndef PKT_FIFO_CFG_SVH
`define PKT_FIFO_CFG_SVH

// --------------------
// storage geometry
// --------------------

// words of storage, power of two
`define PKT_FIFO_DEPTH 16

// bytes per beat
`define PKT_FIFO_DATA_BYTES 4

// --------------------
// packet limits
// --------------------

// longest packet kept, in beats
`define PKT_FIFO_MAX_BEATS 8

`endif

/* pkt_fifo_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo_ctrl
   import pkt_fifo_pkg::*;
(
   input  logic    axi4s_out,
   input  logic    arst_n,
   input  logic    in_valid,
   input  logic    in_last,
   input  logic    over_len,
   input  cnt_t    free,
   input  cnt_t    pkts_ready,
   input  logic    out_ready,
   output mem_op_t op,
   output logic    out_valid,
   output logic    commit_pulse,
   output logic    drop_pulse
);

   logic dropping;  // rest of packet is ignored
   logic accept;    // beat belongs to a live packet
   logic fail;      // beat kills its packet

   // --------------------
   // discard rule
   // --------------------
   assign accept = in_valid && !dropping;
   assign fail   = accept && ((free == '0) || over_len);

   // ignore beats up to and including last of a failed packet
   always_ff @(posedge axi4s_out or negedge arst_n) begin
      if (!arst_n) begin
         dropping <= 1'b0;
      end else if (in_valid) begin
         if (in_last)
            dropping <= 1'b0;  // failing last beat ends it too
         else if (fail)
            dropping <= 1'b1;
      end
   end

   // --------------------
   // ingress strobes
   // --------------------
   assign op.wr       = accept && !fail;
   assign op.commit   = accept && !fail && in_last;  // with the last write
   assign op.rollback = fail;

   // one of each per packet
   assign commit_pulse = op.commit;
   assign drop_pulse   = fail;

   // --------------------
   // egress
   // --------------------
   // whole packets only
   assign out_valid = (pkts_ready != '0);
   assign op.rd     = out_valid && out_ready;

endmodule

`default_nettype wire

/* pkt_fifo_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_fifo_cfg.svh"

module pkt_fifo_mem
   import pkt_fifo_pkg::*;
(
   input  logic      axi4s_out,
   input  logic      arst_n,
   input  mem_op_t   op,
   input  pkt_beat_t wr_beat,
   output pkt_beat_t rd_beat,
   output cnt_t      free,
   output cnt_t      pkts_ready
);

   pkt_beat_t mem [`PKT_FIFO_DEPTH];

   ptr_t wr_ptr;    // next word to write
   ptr_t cmt_ptr;   // first word of the open packet
   ptr_t rd_ptr;    // head of the queue
   cnt_t open_cnt;  // words of the open packet
   cnt_t used_cnt;  // committed words not yet read
   cnt_t pkt_cnt;   // committed packets not yet fully read

   ptr_t wr_ptr_nxt;
   cnt_t open_nxt;

   assign wr_ptr_nxt = wr_ptr + ptr_t'(op.wr);
   assign open_nxt   = open_cnt + cnt_t'(op.wr);

   // --------------------
   // storage array
   // --------------------
   always_ff @(posedge axi4s_out) begin
      if (op.wr) mem[wr_ptr] <= wr_beat;
   end

   assign rd_beat = mem[rd_ptr];  // first word fall through

   // --------------------
   // pointers and counts
   // --------------------
   always_ff @(posedge axi4s_out or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         cmt_ptr  <= '0;
         rd_ptr   <= '0;
         open_cnt <= '0;
         used_cnt <= '0;
         pkt_cnt  <= '0;
      end else begin
         if (op.rollback) begin
            wr_ptr   <= cmt_ptr;  // forget the open packet
            open_cnt <= '0;
         end else if (op.commit) begin
            wr_ptr   <= wr_ptr_nxt;
            cmt_ptr  <= wr_ptr_nxt;  // includes the last beat written now
            open_cnt <= '0;
         end else begin
            wr_ptr   <= wr_ptr_nxt;
            open_cnt <= open_nxt;
         end

         if (op.rd) rd_ptr <= rd_ptr + ptr_t'(1);

         used_cnt <= used_cnt + (op.commit ? open_nxt : cnt_t'(0)) - cnt_t'(op.rd);
         pkt_cnt  <= pkt_cnt + cnt_t'(op.commit) - cnt_t'(op.rd && rd_beat.last);
      end
   end

   // open words count as used
   assign free       = cnt_t'(`PKT_FIFO_DEPTH) - used_cnt - open_cnt;
   assign pkts_ready = pkt_cnt;

endmodule

`default_nettype wire

/* pkt_fifo_pkg.sv */
`default_nettype none

package pkt_fifo_pkg;

`include "pkt_fifo_cfg.svh"

   localparam int PTR_W = $clog2(`PKT_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`PKT_FIFO_DEPTH + 1);

   // --------------------
   // stream beat
   // --------------------
   typedef struct packed {
      logic [8*`PKT_FIFO_DATA_BYTES-1:0] data;
      logic [`PKT_FIFO_DATA_BYTES-1:0]   keep;
      logic                              last;  // end of packet
   } pkt_beat_t;

   typedef logic [PTR_W-1:0] ptr_t;  // storage address
   typedef logic [CNT_W-1:0] cnt_t;  // 0 .. depth

   // packet statistics
   typedef struct packed {
      logic [15:0] pkts_in;       // committed
      logic [15:0] pkts_dropped;  // discarded
   } pkt_fifo_stats_t;

   // strobes from control to storage
   typedef struct packed {
      logic wr;
      logic commit;
      logic rollback;
      logic rd;
   } mem_op_t;

endpackage

`default_nettype wire

/* pkt_fifo_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo_stats
   import pkt_fifo_pkg::*;
(
   input  logic            axi4s_out,
   input  logic            arst_n,
   input  logic            commit_pulse,
   input  logic            drop_pulse,
   output pkt_fifo_stats_t stats,
   output logic            oflow
);

   // --------------------
   // packet counters
   // --------------------
   // both saturate at all ones
   always_ff @(posedge axi4s_out or negedge arst_n) begin
      if (!arst_n) begin
         stats <= '0;
      end else begin
         if (commit_pulse && (stats.pkts_in != '1))
            stats.pkts_in <= stats.pkts_in + 16'd1;
         if (drop_pulse && (stats.pkts_dropped != '1))
            stats.pkts_dropped <= stats.pkts_dropped + 16'd1;
      end
   end

   // one cycle after the failing beat
   always_ff @(posedge axi4s_out or negedge arst_n) begin
      if (!arst_n)
         oflow <= 1'b0;
      else
         oflow <= drop_pulse;
   end

endmodule

`default_nettype wire

/* pkt_fifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_fifo_cfg.svh"

module pkt_fifo_tb
   import pkt_fifo_pkg::*;
();

   localparam int CYCLE_LIMIT = 3000;  // about three times the tests

   logic            axi4s_out;
   logic            arst_n;
   logic            in_valid;
   pkt_beat_t       in_beat;
   logic            out_valid;
   logic            out_ready;
   pkt_beat_t       out_beat;
   pkt_fifo_stats_t stats;
   logic            oflow;

   // --------------------
   // reference model
   // --------------------
   pkt_beat_t exp_q[$];   // committed beats in egress order
   pkt_beat_t open_q[$];  // beats of the open packet
   int        m_used;     // committed words not yet drained
   int        m_pkts;     // committed packets not yet drained
   int        m_len;      // beats seen in the current packet
   int        m_kept;
   int        m_drops;
   bit        m_dropping;
   bit        oflow_exp;
   int        oflow_seen;

   bit        rand_ready;
   logic      ready_level;
   int        errors;
   int        passed;
   int        failed;
   int        cycles;
   string     test_name;

   tb_clk_gen u_clk (
      .axi4s_out (axi4s_out),
      .arst_n    (arst_n)
   );

   pkt_fifo dut (
      .axi4s_out (axi4s_out),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_beat  (out_beat),
      .stats     (stats),
      .oflow     (oflow)
   );

   bind pkt_fifo pkt_fifo_asserts u_asserts (
      .axi4s_out (axi4s_out),
      .arst_n    (arst_n),
      .in_beat   (in_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_beat  (out_beat),
      .oflow     (oflow)
   );

   task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
      errors++;
      $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
   endtask

   // one clock of the model, seen at the falling edge
   task automatic track_cycle();
      bit        exp_valid;
      bit        rd;
      int        free_words;
      pkt_beat_t head;
      exp_valid = (m_pkts != 0);
      if (out_valid !== exp_valid) mismatch("out_valid", 64'(exp_valid), 64'(out_valid));
      if (exp_valid && out_beat !== exp_q[0])
         mismatch("out_beat", 64'(exp_q[0]), 64'(out_beat));
      if (oflow !== oflow_exp) mismatch("oflow", 64'(oflow_exp), 64'(oflow));
      if (oflow === 1'b1) oflow_seen++;
      rd         = exp_valid && out_ready;
      free_words = `PKT_FIFO_DEPTH - m_used - open_q.size();
      oflow_exp  = 1'b0;
      if (in_valid) begin
         if (m_dropping) begin
            if (in_beat.last) m_dropping = 1'b0;
         end else if (free_words == 0 || m_len == `PKT_FIFO_MAX_BEATS) begin
            open_q.delete();  // whole packet lost
            m_drops++;
            oflow_exp  = 1'b1;
            m_dropping = !in_beat.last;
         end else begin
            open_q.push_back(in_beat);
            if (in_beat.last) begin
               m_used += open_q.size();
               foreach (open_q[i]) exp_q.push_back(open_q[i]);
               open_q.delete();
               m_pkts++;
               m_kept++;
            end
         end
         m_len = in_beat.last ? 0 : m_len + 1;
      end
      if (rd) begin
         head = exp_q.pop_front();
         m_used--;
         if (head.last) m_pkts--;
      end
   endtask

   always @(negedge axi4s_out) begin
      if (arst_n) track_cycle();
   end

   always @(posedge axi4s_out) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   // --------------------
   // drivers
   // --------------------
   task automatic drive_cycle(input logic valid, input pkt_beat_t beat);
      @(posedge axi4s_out);
      #1;
      in_valid  = valid;
      in_beat   = beat;
      out_ready = rand_ready ? 1'($urandom) : ready_level;
   endtask

   task automatic send_packet(input int len, input int base, input bit rnd);
      pkt_beat_t beat;
      for (int i = 0; i < len; i++) begin
         beat.data = rnd ? $urandom : 32'(base + i);
         beat.keep = rnd ? 4'($urandom) : 4'hf;
         beat.last = (i == len - 1);
         drive_cycle(1'b1, beat);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || open_q.size() != 0)
         drive_cycle(1'b0, '0);
      repeat (2) drive_cycle(1'b0, '0);  // stats land one edge later
   endtask

   task automatic end_test(input int err0);
      if (errors == err0) begin
         passed++;
         $display("test %s: ok", test_name);
      end else begin
         failed++;
         $display("test %s: %0d errors", test_name, errors - err0);
      end
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_reset();
      int err0;
      err0      = errors;
      test_name = "reset";
      drive_cycle(1'b0, '0);
      if (out_valid !== 1'b0) mismatch("out_valid", 64'd0, 64'(out_valid));
      if (oflow !== 1'b0) mismatch("oflow", 64'd0, 64'(oflow));
      if (stats !== '0) mismatch("stats", 64'd0, 64'(stats));
      end_test(err0);
   endtask

   task automatic test_store_forward();
      int        err0;
      pkt_beat_t beat;
      err0        = errors;
      test_name   = "store_forward";
      ready_level = 1'b1;
      beat.keep   = 4'hf;
      for (int i = 0; i < 4; i++) begin
         beat.data = 32'h5100 + 32'(i);
         beat.last = (i == 3);
         drive_cycle(1'b1, beat);
         if (out_valid !== 1'b0) mismatch("out_valid early", 64'd0, 64'(out_valid));
      end
      drive_cycle(1'b0, '0);
      if (out_valid !== 1'b1) mismatch("out_valid after last", 64'd1, 64'(out_valid));
      wait_drain();
      if (stats.pkts_in !== 16'd1) mismatch("pkts_in", 64'd1, 64'(stats.pkts_in));
      end_test(err0);
   endtask

   task automatic test_overflow();
      int          err0;
      int          seen0;
      logic [15:0] drops0;
      err0        = errors;
      seen0       = oflow_seen;
      drops0      = stats.pkts_dropped;
      test_name   = "overflow";
      ready_level = 1'b0;
      send_packet(6, 'h6100, 1'b0);
      send_packet(6, 'h6200, 1'b0);
      send_packet(6, 'h6300, 1'b0);  // finds free at zero
      repeat (3) drive_cycle(1'b0, '0);
      if (oflow_seen != seen0 + 1) mismatch("oflow pulses", 64'd1, 64'(oflow_seen - seen0));
      if (stats.pkts_dropped !== drops0 + 16'd1)
         mismatch("pkts_dropped", 64'(drops0 + 16'd1), 64'(stats.pkts_dropped));
      ready_level = 1'b1;
      wait_drain();
      send_packet(3, 'h6400, 1'b0);
      wait_drain();
      end_test(err0);
   endtask

   task automatic test_length();
      int          err0;
      logic [15:0] drops0;
      logic [15:0] in0;
      err0        = errors;
      drops0      = stats.pkts_dropped;
      in0         = stats.pkts_in;
      test_name   = "length";
      ready_level = 1'b1;
      send_packet(10, 'h7100, 1'b0);
      send_packet(2, 'h7200, 1'b0);
      wait_drain();
      if (stats.pkts_dropped !== drops0 + 16'd1)
         mismatch("pkts_dropped", 64'(drops0 + 16'd1), 64'(stats.pkts_dropped));
      if (stats.pkts_in !== in0 + 16'd1)
         mismatch("pkts_in", 64'(in0 + 16'd1), 64'(stats.pkts_in));
      end_test(err0);
   endtask

   task automatic test_random();
      int err0;
      err0       = errors;
      test_name  = "random";
      rand_ready = 1'b1;
      for (int p = 0; p < 40; p++) begin
         send_packet(1 + int'($urandom % 10), 0, 1'b1);
         repeat ($urandom % 3) drive_cycle(1'b0, '0);
      end
      rand_ready  = 1'b0;
      ready_level = 1'b1;
      wait_drain();
      if (stats.pkts_in !== 16'(m_kept)) mismatch("pkts_in", 64'(m_kept), 64'(stats.pkts_in));
      if (stats.pkts_dropped !== 16'(m_drops))
         mismatch("pkts_dropped", 64'(m_drops), 64'(stats.pkts_dropped));
      end_test(err0);
   endtask

   initial begin
      void'($urandom(24619));
      in_valid    = 1'b0;
      in_beat     = '0;
      out_ready   = 1'b0;
      ready_level = 1'b0;
      rand_ready  = 1'b0;
      wait (arst_n === 1'b1);
      test_reset();
      test_store_forward();
      test_overflow();
      test_length();
      test_random();
      $display("tests passed: %0d, failed: %0d", passed, failed);
      if (failed == 0 && errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* pkt_len_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_fifo_cfg.svh"

module pkt_len_check (
   input  logic axi4s_out,
   input  logic arst_n,
   input  logic in_valid,
   input  logic in_last,
   output logic sop,
   output logic over_len
);

   // counts to one past the limit, then holds
   localparam int LEN_W = $clog2(`PKT_FIFO_MAX_BEATS + 2);
   localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(`PKT_FIFO_MAX_BEATS);

   logic [LEN_W-1:0] beat_cnt;  // beats seen before the current one

   assign sop      = in_valid && (beat_cnt == '0);
   assign over_len = in_valid && (beat_cnt == LEN_MAX);  // beat number max+1

   // --------------------
   // beat position
   // --------------------
   always_ff @(posedge axi4s_out or negedge arst_n) begin
      if (!arst_n) begin
         beat_cnt <= '0;
      end else if (in_valid) begin
         if (in_last) begin
            beat_cnt <= '0;  // next beat starts a packet
         end else if (sop) begin
            beat_cnt <= LEN_W'(1);
         end else if (beat_cnt <= LEN_MAX) begin
            beat_cnt <= beat_cnt + LEN_W'(1);  // stops past the limit
         end
      end
   end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic axi4s_out,
   output logic arst_n
);

   initial begin
      axi4s_out = 1'b0;
      forever #5 axi4s_out = ~axi4s_out;  // 10 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (3) @(posedge axi4s_out);
      #1 arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
pkt_fifo_pkg.sv
pkt_len_check.sv
pkt_fifo_ctrl.sv
pkt_fifo_mem.sv
pkt_fifo_stats.sv
pkt_fifo.sv
pkt_fifo_asserts.sv
tb_clk_gen.sv
pkt_fifo_tb.sv
